//--- obi_defines.svh
/*
 * Fixed sizes of the three-port OBI slice. OBI_MGR_ID_W must stay equal to
 * OBI_SBR_ID_W plus OBI_SBR_IDX_W, and OBI_SBR_IDX_W must cover OBI_NUM_SBR.
 * OBI_MEM_WORDS is the number of 32-bit words behind the manager port.
 */
`ifndef OBI_DEFINES_SVH
`define OBI_DEFINES_SVH

// Input ports of the multiplexer and the width of a port index.
`define OBI_NUM_SBR 3
`define OBI_SBR_IDX_W 2

// Bus widths.
`define OBI_ADDR_W 32
`define OBI_DATA_W 32
`define OBI_BE_W 4

// The manager side carries the winning port index above the input aid.
`define OBI_SBR_ID_W 2
`define OBI_MGR_ID_W (`OBI_SBR_ID_W + `OBI_SBR_IDX_W)

// Outstanding transactions tracked by the ID FIFO.
`define OBI_MAX_TRANS 4

`define OBI_MEM_WORDS 256

`endif

//--- obi_pkg.sv
/*
 * Channel and port structs for both sides of the OBI multiplexer.
 * Widths come from the defines header; no rready field exists.
 */
`include "obi_defines.svh"

package obi_pkg;

  // A channel as seen at the input ports.
  typedef struct packed {
    logic [`OBI_ADDR_W-1:0]   addr;
    logic                     we;
    logic [`OBI_BE_W-1:0]     be;
    logic [`OBI_DATA_W-1:0]   wdata;
    logic [`OBI_SBR_ID_W-1:0] aid;
  } sbr_a_chan_t;

  // A channel on the manager side, with the widened aid.
  typedef struct packed {
    logic [`OBI_ADDR_W-1:0]   addr;
    logic                     we;
    logic [`OBI_BE_W-1:0]     be;
    logic [`OBI_DATA_W-1:0]   wdata;
    logic [`OBI_MGR_ID_W-1:0] aid;
  } mgr_a_chan_t;

  typedef struct packed {
    logic [`OBI_DATA_W-1:0]   rdata;
    logic                     err;
    logic [`OBI_SBR_ID_W-1:0] rid;
  } sbr_r_chan_t;

  typedef struct packed {
    logic [`OBI_DATA_W-1:0]   rdata;
    logic                     err;
    logic [`OBI_MGR_ID_W-1:0] rid;
  } mgr_r_chan_t;

  typedef struct packed {
    logic        req;
    sbr_a_chan_t a;
  } sbr_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    sbr_r_chan_t r;
  } sbr_rsp_t;

  typedef struct packed {
    logic        req;
    mgr_a_chan_t a;
  } mgr_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    mgr_r_chan_t r;
  } mgr_rsp_t;

endpackage

//--- obi_rr_arb.sv
/*
 * Lock-in round-robin arbiter. A requester must hold req and its A channel
 * until granted. The pointer starts at port 0 and is never flushed.
 */
`include "obi_defines.svh"

module obi_rr_arb (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic [`OBI_NUM_SBR-1:0]                 req_i,
  input  obi_pkg::sbr_a_chan_t [`OBI_NUM_SBR-1:0] a_i,
  output logic [`OBI_NUM_SBR-1:0]                 gnt_o,
  output logic                                    req_o,
  output obi_pkg::sbr_a_chan_t                    a_o,
  output logic [`OBI_SBR_IDX_W-1:0]               idx_o,
  input  logic                                    gnt_i
);

  logic [`OBI_SBR_IDX_W-1:0] ptr_q;
  logic [`OBI_SBR_IDX_W-1:0] lock_idx_q;
  logic [`OBI_SBR_IDX_W-1:0] cand;
  logic [`OBI_SBR_IDX_W-1:0] pick;
  logic                      lock_q;
  logic                      found;

  // Walk the ports starting at the pointer and take the first one that requests.
  always_comb begin
    found = 1'b0;
    pick  = ptr_q;
    cand  = ptr_q;
    for (int i = 0; i < `OBI_NUM_SBR; i++) begin
      if (!found && req_i[cand]) begin
        found = 1'b1;
        pick  = cand;
      end
      cand = (cand == `OBI_NUM_SBR - 1) ? '0 : cand + 1'b1;
    end
  end

  // A pending request that was not granted keeps its slot until it is.
  assign idx_o = lock_q ? lock_idx_q : pick;
  assign req_o = req_i[idx_o];
  assign a_o   = a_i[idx_o];

  always_comb begin
    gnt_o        = '0;
    gnt_o[idx_o] = req_o && gnt_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q <= req_o && !gnt_i;
      if (req_o && !gnt_i) begin
        lock_idx_q <= idx_o;
      end
      // After a handshake the winner gets the lowest priority.
      if (req_o && gnt_i) begin
        ptr_q <= (idx_o == `OBI_NUM_SBR - 1) ? '0 : idx_o + 1'b1;
      end
    end
  end

  // A requester that is kept waiting holds req and its A channel.
  assert property (@(posedge clk_i) disable iff (rst_i)
                   lock_q |-> req_i[lock_idx_q] && (a_i[lock_idx_q] == $past(a_o)))
    else $error("Locked requester dropped req or changed its A channel.");

endmodule

//--- obi_id_fifo.sv
/*
 * FIFO of port indices for outstanding transactions, OBI_MAX_TRANS deep.
 * Not fall-through. Pop on empty is illegal; push on full needs a pop.
 */
`include "obi_defines.svh"

module obi_id_fifo (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      push_i,
  input  logic [`OBI_SBR_IDX_W-1:0] data_i,
  input  logic                      pop_i,
  output logic [`OBI_SBR_IDX_W-1:0] data_o,
  output logic                      full_o,
  output logic                      empty_o
);

  logic [`OBI_SBR_IDX_W-1:0]          mem_q [`OBI_MAX_TRANS];
  logic [$clog2(`OBI_MAX_TRANS)-1:0]  wr_ptr_q;
  logic [$clog2(`OBI_MAX_TRANS)-1:0]  rd_ptr_q;
  logic [$clog2(`OBI_MAX_TRANS+1)-1:0] count_q;
  logic                               do_push;
  logic                               do_pop;

  assign full_o  = (count_q == `OBI_MAX_TRANS);
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  // A full FIFO still takes a push when the head leaves in the same cycle.
  assign do_pop  = pop_i && !empty_o;
  assign do_push = push_i && (!full_o || do_pop);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == `OBI_MAX_TRANS - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == `OBI_MAX_TRANS - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
                   !(pop_i && empty_o) && !(push_i && full_o && !pop_i))
    else $error("ID FIFO overflow or underflow.");

endmodule

//--- obi_mux.sv
/*
 * OBI multiplexer from OBI_NUM_SBR input ports to one manager port.
 * Responses must return in grant order and are always accepted.
 * The widened aid is informational; routing uses the ID FIFO only.
 */
`include "obi_defines.svh"

module obi_mux (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  obi_pkg::sbr_req_t [`OBI_NUM_SBR-1:0] sbr_req_i,
  output obi_pkg::sbr_rsp_t [`OBI_NUM_SBR-1:0] sbr_rsp_o,
  output obi_pkg::mgr_req_t                    mgr_req_o,
  input  obi_pkg::mgr_rsp_t                    mgr_rsp_i
);

  import obi_pkg::*;

  logic [`OBI_NUM_SBR-1:0]        sbr_req;
  logic [`OBI_NUM_SBR-1:0]        sbr_gnt;
  sbr_a_chan_t [`OBI_NUM_SBR-1:0] sbr_a;
  sbr_a_chan_t                    arb_a;
  logic                           arb_req;
  logic [`OBI_SBR_IDX_W-1:0]      win_idx;
  logic [`OBI_SBR_IDX_W-1:0]      rsp_idx;
  logic                           fifo_full;
  logic                           fifo_empty;
  logic                           mgr_hs;

  for (genvar i = 0; i < `OBI_NUM_SBR; i++) begin : gen_sbr_split
    assign sbr_req[i] = sbr_req_i[i].req;
    assign sbr_a[i]   = sbr_req_i[i].a;
  end

  // No new grant while every ID FIFO slot is taken.
  obi_rr_arb i_rr_arb (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (sbr_req),
    .a_i   (sbr_a),
    .gnt_o (sbr_gnt),
    .req_o (arb_req),
    .a_o   (arb_a),
    .idx_o (win_idx),
    .gnt_i (mgr_rsp_i.gnt && !fifo_full)
  );

  assign mgr_req_o.req     = arb_req && !fifo_full;
  assign mgr_req_o.a.addr  = arb_a.addr;
  assign mgr_req_o.a.we    = arb_a.we;
  assign mgr_req_o.a.be    = arb_a.be;
  assign mgr_req_o.a.wdata = arb_a.wdata;
  assign mgr_req_o.a.aid   = {win_idx, arb_a.aid};

  assign mgr_hs = mgr_req_o.req && mgr_rsp_i.gnt;

  obi_id_fifo i_id_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (mgr_hs),
    .data_i  (win_idx),
    .pop_i   (mgr_rsp_i.rvalid),
    .data_o  (rsp_idx),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  // The oldest outstanding index picks the port that sees the response.
  always_comb begin
    for (int i = 0; i < `OBI_NUM_SBR; i++) begin
      sbr_rsp_o[i]     = '0;
      sbr_rsp_o[i].gnt = sbr_gnt[i];
      if (rsp_idx == i) begin
        sbr_rsp_o[i].rvalid  = mgr_rsp_i.rvalid;
        sbr_rsp_o[i].r.rdata = mgr_rsp_i.r.rdata;
        sbr_rsp_o[i].r.err   = mgr_rsp_i.r.err;
        sbr_rsp_o[i].r.rid   = mgr_rsp_i.r.rid[`OBI_SBR_ID_W-1:0];
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
                   mgr_rsp_i.rvalid |-> !fifo_empty)
    else $error("Response without an outstanding transaction.");

endmodule

//--- obi_sram.sv
/*
 * Word-addressed OBI memory of OBI_MEM_WORDS words, always granting.
 * rvalid follows the handshake by exactly two cycles. Out-of-range accesses
 * set err; such writes are dropped and reads, like all writes, return zero.
 */
`include "obi_defines.svh"

module obi_sram (
  input  logic              clk_i,
  input  logic              rst_i,
  input  obi_pkg::mgr_req_t req_i,
  output obi_pkg::mgr_rsp_t rsp_o
);

  import obi_pkg::*;

  logic [`OBI_DATA_W-1:0]             mem_q [`OBI_MEM_WORDS];
  logic [$clog2(`OBI_MEM_WORDS)-1:0]  word_idx;
  logic                               out_of_range;

  // First stage holds the request, second stage the finished response.
  logic                               s1_valid_q;
  logic                               s1_we_q;
  logic                               s1_err_q;
  logic [`OBI_MGR_ID_W-1:0]           s1_aid_q;
  logic [$clog2(`OBI_MEM_WORDS)-1:0]  s1_idx_q;
  logic                               s2_valid_q;
  mgr_r_chan_t                        s2_r_q;

  assign word_idx     = req_i.a.addr[2 +: $clog2(`OBI_MEM_WORDS)];
  assign out_of_range = (req_i.a.addr[`OBI_ADDR_W-1:2] >= `OBI_MEM_WORDS);

  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.a.we && !out_of_range) begin
      for (int b = 0; b < `OBI_BE_W; b++) begin
        if (req_i.a.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= req_i.a.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    s1_we_q  <= req_i.a.we;
    s1_err_q <= out_of_range;
    s1_aid_q <= req_i.a.aid;
    s1_idx_q <= word_idx;
    // The read sees a write from the previous cycle.
    s2_r_q.rdata <= (s1_we_q || s1_err_q) ? '0 : mem_q[s1_idx_q];
    s2_r_q.err   <= s1_err_q;
    s2_r_q.rid   <= s1_aid_q;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= req_i.req;
      s2_valid_q <= s1_valid_q;
    end
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = s2_valid_q;
  assign rsp_o.r      = s2_r_q;

  assert property (@(posedge clk_i) disable iff (rst_i)
                   req_i.req |-> !$isunknown({req_i.a.addr, req_i.a.we, req_i.a.be}))
    else $error("Memory request with unknown address or control.");

endmodule

//--- obi_mux_sys.sv
/*
 * Three OBI input ports sharing one pipelined memory through the
 * multiplexer. Responses return two cycles after the grant.
 */
`include "obi_defines.svh"

module obi_mux_sys (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  obi_pkg::sbr_req_t [`OBI_NUM_SBR-1:0] sbr_req_i,
  output obi_pkg::sbr_rsp_t [`OBI_NUM_SBR-1:0] sbr_rsp_o
);

  import obi_pkg::*;

  mgr_req_t mgr_req;
  mgr_rsp_t mgr_rsp;

  obi_mux i_obi_mux (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .sbr_req_i (sbr_req_i),
    .sbr_rsp_o (sbr_rsp_o),
    .mgr_req_o (mgr_req),
    .mgr_rsp_i (mgr_rsp)
  );

  obi_sram i_obi_sram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (mgr_req),
    .rsp_o (mgr_rsp)
  );

endmodule

//--- tb_obi_mux_sys.sv
/*
 * Directed testbench for the three-port OBI slice. Expected responses come from
 * a reference memory that is updated in grant order; tests read only words
 * that were written before. The run stops after 2000 cycles at the latest.
 */
`include "obi_defines.svh"

module tb_obi_mux_sys;
  timeunit 1ns;
  timeprecision 1ps;

  import obi_pkg::*;

  localparam int NP = `OBI_NUM_SBR;
  // The whole sequence needs about 250 cycles, so 2000 leaves a wide margin.
  localparam int MAX_CYCLES = 2000;

  typedef struct packed {
    sbr_r_chan_t r;
    logic [31:0] cyc;
  } exp_t;

  logic                     clk;
  logic                     rst;
  sbr_req_t [NP-1:0]        sbr_req;
  sbr_rsp_t [NP-1:0]        sbr_rsp;
  logic [`OBI_DATA_W-1:0]   ref_mem [`OBI_MEM_WORDS];
  sbr_a_chan_t              pend_q [NP][$];
  exp_t                     exp_q [NP][$];
  sbr_a_chan_t              cur [NP];
  sbr_r_chan_t              last_rsp [NP];
  bit                       busy [NP];
  bit                       granted [NP];
  int                       rsp_cnt [NP];
  int                       grant_log [$];
  int                       written_q [$];
  int                       cycle_cnt = 0;
  int                       errors = 0;
  int                       checks = 0;
  int                       tests_run = 0;

  obi_mux_sys obi_mux_sys_i (
    .clk_i     (clk),
    .rst_i     (rst),
    .sbr_req_i (sbr_req),
    .sbr_rsp_o (sbr_rsp)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the tests did not complete within %0d cycles.", MAX_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_error(input string what);
    $display("Error at %0t: %s", $time, what);
    errors++;
  endtask

  // Memory model: byte-lane writes, range error, and zero data for writes.
  function automatic exp_t model_access(input sbr_a_chan_t a);
    exp_t                   e;
    logic [`OBI_ADDR_W-3:0] word;
    word       = a.addr[`OBI_ADDR_W-1:2];
    e.cyc      = cycle_cnt;
    e.r.rid    = a.aid;
    e.r.err    = (word >= `OBI_MEM_WORDS);
    e.r.rdata  = (a.we || e.r.err) ? '0 : ref_mem[word[7:0]];
    if (a.we && !e.r.err) begin
      for (int b = 0; b < `OBI_BE_W; b++) begin
        if (a.be[b]) begin
          ref_mem[word[7:0]][8*b +: 8] = a.wdata[8*b +: 8];
        end
      end
    end
    return e;
  endfunction

  // Called 1 ns before the rising edge, when every output has settled.
  task automatic collect_outputs();
    int   n_gnt;
    int   n_rv;
    exp_t e;
    n_gnt = 0;
    n_rv  = 0;
    for (int p = 0; p < NP; p++) begin
      granted[p] = sbr_rsp[p].gnt && busy[p];
      if (rst && (sbr_rsp[p].gnt || sbr_rsp[p].rvalid)) begin
        report_error($sformatf("port %0d shows gnt or rvalid during reset", p));
      end
      if (sbr_rsp[p].gnt) begin
        n_gnt++;
        if (!busy[p]) begin
          report_error($sformatf("port %0d was granted without a request", p));
        end else begin
          grant_log.push_back(p);
          exp_q[p].push_back(model_access(cur[p]));
        end
      end
      if (sbr_rsp[p].rvalid) begin
        n_rv++;
        if (exp_q[p].size() == 0) begin
          report_error($sformatf("response on port %0d with nothing outstanding", p));
        end else begin
          e = exp_q[p].pop_front();
          last_rsp[p] = sbr_rsp[p].r;
          rsp_cnt[p]++;
          check_eq(sbr_rsp[p].r, e.r, $sformatf("port %0d rdata/err/rid", p));
          check_eq(cycle_cnt, e.cyc + 2, $sformatf("port %0d response latency", p));
        end
      end
    end
    if (n_gnt > 1) begin
      report_error("more than one port granted in one cycle");
    end
    if (n_rv > 1) begin
      report_error("more than one port shows rvalid in one cycle");
    end
  endtask

  // Each port holds its request until it is granted, then takes the next one.
  always @(negedge clk) begin
    for (int p = 0; p < NP; p++) begin
      if (busy[p] && granted[p]) begin
        busy[p] = 1'b0;
      end
      if (!busy[p] && pend_q[p].size() > 0) begin
        cur[p]  = pend_q[p].pop_front();
        busy[p] = 1'b1;
      end
      sbr_req[p].req = busy[p];
      sbr_req[p].a   = busy[p] ? cur[p] : '0;
    end
    #1;
    collect_outputs();
  end

  task automatic queue_req(input int port, input logic we, input logic [31:0] word,
                           input logic [3:0] be, input logic [31:0] wdata,
                           input logic [1:0] aid);
    sbr_a_chan_t a;
    a.addr  = word << 2;
    a.we    = we;
    a.be    = be;
    a.wdata = wdata;
    a.aid   = aid;
    pend_q[port].push_back(a);
  endtask

  function automatic bit all_idle();
    for (int p = 0; p < NP; p++) begin
      if (busy[p] || pend_q[p].size() != 0 || exp_q[p].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic wait_idle();
    while (!all_idle()) begin
      @(posedge clk);
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (3) @(negedge clk);
    rst = 1'b0;
  endtask

  function automatic int random_written();
    return written_q[$urandom_range(0, written_q.size() - 1)];
  endfunction

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    $display("Test %-22s %s", name, (errors == err_start) ? "ok" : "with errors");
  endtask

  task automatic test_reset_state();
    int err_start;
    int w;
    err_start = errors;
    wait_idle();
    apply_reset();
    repeat (2) begin
      @(negedge clk);
      #1;
      for (int p = 0; p < NP; p++) begin
        check_eq({sbr_rsp[p].gnt, sbr_rsp[p].rvalid}, 0, "outputs idle after reset");
      end
    end
    @(posedge clk);
    grant_log.delete();
    for (int p = 1; p < NP; p++) begin
      w = $urandom_range(0, `OBI_MEM_WORDS - 1);
      written_q.push_back(w);
      queue_req(p, 1'b1, w, 4'hf, $urandom, 2'(p));
    end
    wait_idle();
    check_eq(grant_log.size(), 2, "grants after reset");
    check_eq(grant_log[0], 1, "first grant after reset");
    finish_test("reset state", err_start);
  endtask

  task automatic test_single_write_read();
    int err_start;
    err_start = errors;
    @(posedge clk);
    queue_req(0, 1'b1, 32'd5, 4'hf, 32'hcafe_0105, 2'd1);
    written_q.push_back(5);
    queue_req(0, 1'b0, 32'd5, 4'h0, 32'h0, 2'd2);
    wait_idle();
    check_eq(last_rsp[0].rdata, 32'hcafe_0105, "read back of word 5");
    check_eq(last_rsp[0].rid, 2'd2, "rid of read back");
    check_eq(last_rsp[0].err, 1'b0, "err of read back");
    finish_test("single write and read", err_start);
  endtask

  task automatic test_byte_enables();
    int err_start;
    int w;
    err_start = errors;
    @(posedge clk);
    for (int p = 0; p < NP; p++) begin
      for (int k = 0; k < 4; k++) begin
        w = $urandom_range(0, `OBI_MEM_WORDS - 1);
        written_q.push_back(w);
        queue_req(p, 1'b1, w, 4'hf, $urandom, 2'(k));
        queue_req(p, 1'b1, w, 4'($urandom_range(1, 14)), $urandom, 2'(k + 1));
        queue_req(p, 1'b0, w, 4'h0, 32'h0, 2'(k + 2));
      end
    end
    wait_idle();
    finish_test("byte enables", err_start);
  endtask

  task automatic test_round_robin();
    int err_start;
    err_start = errors;
    wait_idle();
    // A read is still in the memory pipeline when reset hits, so its
    // response must never appear.
    queue_req(0, 1'b0, random_written(), 4'h0, 32'h0, 2'd0);
    do begin
      @(negedge clk);
    end while (!granted[0]);
    apply_reset();
    exp_q[0].delete();
    // The pointer restarts at port 0, so the order is known from the start.
    @(posedge clk);
    grant_log.delete();
    for (int k = 0; k < 5; k++) begin
      for (int p = 0; p < NP; p++) begin
        queue_req(p, 1'b0, random_written(), 4'h0, 32'h0, 2'(k));
      end
    end
    wait_idle();
    check_eq(grant_log.size(), 5 * NP, "number of grants");
    foreach (grant_log[i]) begin
      check_eq(grant_log[i], i % NP, $sformatf("port of grant %0d", i));
    end
    finish_test("round robin", err_start);
  endtask

  task automatic test_response_routing();
    int err_start;
    int start_cnt [NP];
    err_start = errors;
    @(posedge clk);
    for (int p = 0; p < NP; p++) begin
      start_cnt[p] = rsp_cnt[p];
    end
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < NP; p++) begin
        queue_req(p, 1'b0, random_written(), 4'h0, 32'h0, 2'(p + k));
      end
    end
    wait_idle();
    for (int p = 0; p < NP; p++) begin
      check_eq(rsp_cnt[p] - start_cnt[p], 6, $sformatf("responses on port %0d", p));
    end
    finish_test("response routing", err_start);
  endtask

  task automatic test_out_of_range();
    int err_start;
    err_start = errors;
    @(posedge clk);
    queue_req(0, 1'b1, 32'd0, 4'hf, 32'h1234_5678, 2'd0);
    written_q.push_back(0);
    // Word 256 aliases word 0 if the range check fails.
    queue_req(2, 1'b1, `OBI_MEM_WORDS, 4'hf, 32'hdead_beef, 2'd1);
    queue_req(1, 1'b0, 32'd300, 4'h0, 32'h0, 2'd2);
    queue_req(1, 1'b0, 32'h3fff_ffff, 4'h0, 32'h0, 2'd3);
    wait_idle();
    check_eq(last_rsp[2].err, 1'b1, "err of out-of-range write");
    check_eq(last_rsp[1].err, 1'b1, "err of out-of-range read");
    check_eq(last_rsp[1].rdata, 32'h0, "rdata of out-of-range read");
    queue_req(0, 1'b0, 32'd0, 4'h0, 32'h0, 2'd3);
    wait_idle();
    check_eq(last_rsp[0].rdata, 32'h1234_5678, "word 0 after out-of-range write");
    finish_test("out of range", err_start);
  endtask

  initial begin
    void'($urandom(32'h3718_ba7c));
    clk     = 1'b0;
    rst     = 1'b1;
    sbr_req = '0;
    test_reset_state();
    test_single_write_read();
    test_byte_enables();
    test_round_robin();
    test_response_routing();
    test_out_of_range();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- obi_mux_sys.f
+incdir+.
obi_pkg.sv
obi_rr_arb.sv
obi_id_fifo.sv
obi_mux.sv
obi_sram.sv
obi_mux_sys.sv
tb_obi_mux_sys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the OBI multiplexer testbench with Verilator, runs it and scans the log.
set -euo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f obi_mux_sys.f \
  --top-module tb_obi_mux_sys \
  -o sim_obi_mux_sys

./obj_dir/sim_obi_mux_sys 2>&1 | tee "$LOG"

if grep -q '\*\* FAIL \*\*' "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi

echo "Simulation reported no failure"
